/* Bender.yml */
package:
  name: aud_capture

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/aud_pkg.sv
      - src/aud_recorder.sv
      - src/sample_fifo.sv
      - src/sram_writer.sv
      - src/aud_capture_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_aud_capture.sv

/* include/aud_settings.svh */
`ifndef AUD_SETTINGS_SVH
`define AUD_SETTINGS_SVH

// **************************************************
// audio capture sizing
// **************************************************

// width of one mono sample in bits.
`define AUD_SAMPLE_W 16

// sram word address width.
`define AUD_ADDR_W 20

// default number of samples before the sram counts as full.
`define AUD_MAX_SAMPLES 1024000

// entries in the sample buffer between recorder and writer.
`define AUD_FIFO_DEPTH 4

`endif

/* src/aud_capture_top.sv */
`include "aud_settings.svh"

module aud_capture_top
    import aud_pkg::*;
#(
    parameter int FIFO_DEPTH  = `AUD_FIFO_DEPTH,
    parameter int MAX_SAMPLES = `AUD_MAX_SAMPLES
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_lrc,
    input  logic    i_data,
    input  logic    i_start,
    input  logic    i_pause,
    input  logic    i_stop,
    input  logic    i_sram_grant,
    output logic    o_sram_we,
    output addr_t   o_sram_addr,
    output sample_t o_sram_data,
    output logic    o_busy,
    output logic    o_full,
    output logic    o_overrun
);

    logic    rec_start;
    logic    smp_valid;
    sample_t smp_data;
    sample_t head_data;
    logic    not_empty;
    logic    pop;

    // **************************************************
    // recorder -> fifo -> writer
    // **************************************************
    aud_recorder u_recorder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_lrc       (i_lrc),
        .i_data      (i_data),
        .i_start     (i_start),
        .i_pause     (i_pause),
        .i_stop      (i_stop),
        .o_rec_start (rec_start),
        .o_smp_valid (smp_valid),
        .o_smp_data  (smp_data),
        .o_busy      (o_busy)
    );

    sample_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_clear     (rec_start),
        .i_push      (smp_valid),
        .i_pop       (pop),
        .i_data      (smp_data),
        .o_head      (head_data),
        .o_not_empty (not_empty),
        .o_overrun   (o_overrun)
    );

    sram_writer #(
        .MAX_SAMPLES (MAX_SAMPLES)
    ) u_writer (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_clear      (rec_start),               // restart at address 0.
        .i_not_empty  (not_empty),
        .i_sram_grant (i_sram_grant),
        .i_head       (head_data),
        .o_pop        (pop),
        .o_sram_we    (o_sram_we),
        .o_sram_addr  (o_sram_addr),
        .o_sram_data  (o_sram_data),
        .o_full       (o_full)
    );

endmodule

/* src/aud_pkg.sv */
`include "aud_settings.svh"

package aud_pkg;

    typedef logic [`AUD_SAMPLE_W-1:0] sample_t;   // one audio sample.
    typedef logic [`AUD_ADDR_W-1:0]   addr_t;     // sram word address.

    // recorder control states.
    typedef enum logic [2:0] {
        REC_IDLE,
        REC_WAIT,
        REC_SHIFT,
        REC_PAUSE,
        REC_FINISH
    } rec_state_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_RUN,
        WR_FULL                                   // drains only after the limit.
    } wr_state_e;

endpackage

/* src/aud_recorder.sv */
`include "aud_settings.svh"

module aud_recorder
    import aud_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_lrc,
    input  logic    i_data,
    input  logic    i_start,
    input  logic    i_pause,
    input  logic    i_stop,
    output logic    o_rec_start,
    output logic    o_smp_valid,
    output sample_t o_smp_data,
    output logic    o_busy
);

    rec_state_e state_r, state_w;
    logic       lrc_r;
    logic [3:0] cnt_r, cnt_w;
    sample_t    shift_r, shift_w;
    logic       valid_r, valid_w;
    logic       start_r, start_w;
    logic       frame_edge;

    assign frame_edge  = lrc_r && !i_lrc;         // lrc just went low.
    assign o_rec_start = start_r;
    assign o_smp_valid = valid_r;
    assign o_smp_data  = shift_r;
    assign o_busy      = (state_r != REC_IDLE);

    // **************************************************
    // control fsm
    // **************************************************
    always_comb begin
        state_w = state_r;
        cnt_w   = cnt_r;
        shift_w = shift_r;
        valid_w = 1'b0;
        start_w = 1'b0;
        case (state_r)
            REC_IDLE: begin
                if (i_start) begin
                    state_w = REC_WAIT;
                    start_w = 1'b1;
                end
            end
            REC_WAIT: begin
                if (i_stop) begin
                    state_w = REC_FINISH;
                end else if (i_pause) begin
                    state_w = REC_PAUSE;
                end else if (frame_edge) begin
                    // this edge carries the msb.
                    shift_w = {shift_r[`AUD_SAMPLE_W-2:0], i_data};
                    cnt_w   = 4'(`AUD_SAMPLE_W - 2);
                    state_w = REC_SHIFT;
                end
            end
            REC_SHIFT: begin
                if (i_stop) begin
                    state_w = REC_FINISH;             // partial frame lost.
                end else if (i_pause) begin
                    state_w = REC_PAUSE;
                end else begin
                    shift_w = {shift_r[`AUD_SAMPLE_W-2:0], i_data};
                    if (cnt_r == 4'd0) begin
                        valid_w = 1'b1;
                        state_w = REC_WAIT;
                    end else begin
                        cnt_w = cnt_r - 4'd1;
                    end
                end
            end
            REC_PAUSE: begin
                if (i_stop) begin
                    state_w = REC_FINISH;
                end else if (i_pause) begin
                    state_w = REC_WAIT;               // resume.
                end
            end
            REC_FINISH: state_w = REC_IDLE;
            default:    state_w = REC_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r <= REC_IDLE;
            lrc_r   <= 1'b0;
            cnt_r   <= 4'd0;
            valid_r <= 1'b0;
            start_r <= 1'b0;
        end else begin
            state_r <= state_w;
            lrc_r   <= i_lrc;
            cnt_r   <= cnt_w;
            valid_r <= valid_w;
            start_r <= start_w;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
    end

    // **************************************************
    // checks
    // **************************************************
    a_no_valid_in_pause: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (state_r == REC_PAUSE) |-> !o_smp_valid);

    a_rec_start_pulse: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_rec_start |=> !o_rec_start);

endmodule

/* src/sample_fifo.sv */
`include "aud_settings.svh"

module sample_fifo
    import aud_pkg::*;
#(
    parameter int DEPTH = `AUD_FIFO_DEPTH
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_clear,
    input  logic    i_push,
    input  logic    i_pop,
    input  sample_t i_data,
    output sample_t o_head,
    output logic    o_not_empty,
    output logic    o_overrun
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sample_t          mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr_r, wr_ptr_r;
    logic [CNT_W-1:0] count_r;
    logic             overrun_r;
    logic             empty, full, do_push, do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty       = (count_r == '0);
    assign full        = (count_r == CNT_W'(DEPTH));
    assign do_pop      = i_pop && !empty;
    assign do_push     = i_push && (!full || do_pop);  // full slot frees this cycle.
    assign o_head      = mem[rd_ptr_r];
    assign o_not_empty = !empty;
    assign o_overrun   = overrun_r;

    always_ff @(posedge i_clk) begin
        if (i_rst_n || i_clear) begin
            rd_ptr_r  <= '0;
            wr_ptr_r  <= '0;
            count_r   <= '0;
            overrun_r <= 1'b0;
        end else begin
            if (do_push) wr_ptr_r <= next_ptr(wr_ptr_r);
            if (do_pop)  rd_ptr_r <= next_ptr(rd_ptr_r);
            case ({do_push, do_pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
            if (i_push && !do_push) overrun_r <= 1'b1;  // sample dropped.
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) mem[wr_ptr_r] <= i_data;
    end

    a_no_pop_empty: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_pop |-> !empty);

endmodule

/* src/sram_writer.sv */
`include "aud_settings.svh"

module sram_writer
    import aud_pkg::*;
#(
    parameter int MAX_SAMPLES = `AUD_MAX_SAMPLES
) (
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_clear,
    input  logic    i_not_empty,
    input  logic    i_sram_grant,
    input  sample_t i_head,
    output logic    o_pop,
    output logic    o_sram_we,
    output addr_t   o_sram_addr,
    output sample_t o_sram_data,
    output logic    o_full
);

    wr_state_e state_r, state_w;
    addr_t     addr_r, addr_w;
    logic      write;

    // a write needs both a sample and the port.
    assign write       = (state_r == WR_RUN) && i_not_empty && i_sram_grant;
    assign o_pop       = write || ((state_r == WR_FULL) && i_not_empty);
    assign o_sram_we   = write;
    assign o_sram_addr = addr_r;
    assign o_sram_data = i_head;
    assign o_full      = (state_r == WR_FULL);

    always_comb begin
        state_w = state_r;
        addr_w  = addr_r;
        if (i_clear) begin
            state_w = WR_RUN;                         // new recording.
            addr_w  = '0;
        end else begin
            case (state_r)
                WR_RUN: begin
                    if (write) begin
                        if (addr_r == addr_t'(MAX_SAMPLES - 1)) begin
                            state_w = WR_FULL;
                        end else begin
                            addr_w = addr_r + 1'b1;
                        end
                    end
                end
                WR_IDLE: state_w = WR_IDLE;
                WR_FULL: state_w = WR_FULL;           // only a clear leaves.
                default: state_w = WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r <= WR_IDLE;
            addr_r  <= '0;
        end else begin
            state_r <= state_w;
            addr_r  <= addr_w;
        end
    end

    a_addr_in_range: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_sram_we |-> (32'(o_sram_addr) < MAX_SAMPLES));

endmodule

/* tb.f */
+incdir+include
src/aud_pkg.sv
src/aud_recorder.sv
src/sample_fifo.sv
src/sram_writer.sv
src/aud_capture_top.sv
verif/tb_aud_capture.sv

/* verif/tb_aud_capture.sv */
module tb_aud_capture
    import aud_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 40;
    localparam int FRAME_CYCLES = 21;                 // 2 header, 16 bits, 3 tail.
    localparam int NUM_ROWS     = 27;
    localparam int WATCHDOG_NS  = (NUM_ROWS * 40 * FRAME_CYCLES + 10) * CLK_PERIOD;

    typedef enum logic [2:0] {ACT_NONE, ACT_START, ACT_PAUSE, ACT_RESUME, ACT_STOP, ACT_CUT} act_e;
    typedef enum logic [1:0] {GNT_ON, GNT_OFF, GNT_RAND} gnt_e;
    typedef struct packed {
        sample_t value;
        act_e    act;
        gnt_e    gnt;
        logic    keep;
        logic    busy;
        logic    full;
        logic    ovr;
    } row_t;

    // value (0 takes lfsr bits), action, grant, kept, then busy, full, overrun after the frame.
    row_t rows [NUM_ROWS] = '{
        '{16'h8001, ACT_START,  GNT_ON,   1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h0000, ACT_NONE,   GNT_ON,   1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h1234, ACT_CUT,    GNT_ON,   1'b0, 1'b1, 1'b0, 1'b0},
        '{16'h4c3a, ACT_RESUME, GNT_ON,   1'b1, 1'b1, 1'b0, 1'b0},
        '{16'hdead, ACT_PAUSE,  GNT_ON,   1'b0, 1'b1, 1'b0, 1'b0},
        '{16'hbeef, ACT_RESUME, GNT_ON,   1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h5555, ACT_STOP,   GNT_ON,   1'b0, 1'b0, 1'b0, 1'b0},
        '{16'h0000, ACT_START,  GNT_RAND, 1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h0000, ACT_NONE,   GNT_RAND, 1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h7ffe, ACT_NONE,   GNT_ON,   1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h0001, ACT_NONE,   GNT_OFF,  1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h0000, ACT_NONE,   GNT_OFF,  1'b1, 1'b1, 1'b0, 1'b0},
        '{16'hffff, ACT_NONE,   GNT_OFF,  1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h0000, ACT_NONE,   GNT_OFF,  1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h0000, ACT_NONE,   GNT_ON,   1'b1, 1'b1, 1'b1, 1'b0},  // eighth write.
        '{16'h2468, ACT_NONE,   GNT_ON,   1'b0, 1'b1, 1'b1, 1'b0},
        '{16'h1357, ACT_STOP,   GNT_ON,   1'b0, 1'b0, 1'b1, 1'b0},
        '{16'ha5a5, ACT_START,  GNT_ON,   1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h0000, ACT_NONE,   GNT_OFF,  1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h0f0f, ACT_NONE,   GNT_OFF,  1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h0000, ACT_NONE,   GNT_OFF,  1'b1, 1'b1, 1'b0, 1'b0},
        '{16'hc001, ACT_NONE,   GNT_OFF,  1'b1, 1'b1, 1'b0, 1'b0},
        '{16'h3333, ACT_NONE,   GNT_OFF,  1'b0, 1'b1, 1'b0, 1'b1},  // buffer full.
        '{16'h0000, ACT_NONE,   GNT_OFF,  1'b0, 1'b1, 1'b0, 1'b1},
        '{16'h0000, ACT_NONE,   GNT_ON,   1'b1, 1'b1, 1'b0, 1'b1},
        '{16'h6666, ACT_STOP,   GNT_ON,   1'b0, 1'b0, 1'b0, 1'b1},
        '{16'h00ff, ACT_START,  GNT_ON,   1'b1, 1'b1, 1'b0, 1'b0}
    };

    logic    clk, rst_n, lrc, sdata, start, pause, stop, grant;
    logic    sram_we, busy, full, overrun;
    addr_t   sram_addr, exp_addr;
    sample_t sram_data;
    sample_t exp_q [$];
    logic [31:0] lfsr = 32'hd58f;

    aud_capture_top #(
        .FIFO_DEPTH  (4),
        .MAX_SAMPLES (8)
    ) DUT (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_lrc        (lrc),
        .i_data       (sdata),
        .i_start      (start),
        .i_pause      (pause),
        .i_stop       (stop),
        .i_sram_grant (grant),
        .o_sram_we    (sram_we),
        .o_sram_addr  (sram_addr),
        .o_sram_data  (sram_data),
        .o_busy       (busy),
        .o_full       (full),
        .o_overrun    (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // **************************************************
    // helpers
    // **************************************************
    function automatic logic rand_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic grant_for(input gnt_e mode);
        case (mode)
            GNT_ON:  return 1'b1;
            GNT_OFF: return 1'b0;
            default: return rand_bit();
        endcase
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (act !== exp)
            abort_run($sformatf("error at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
            abort_run($sformatf("error at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("error at %0t ns: %s expected %b, got %b", $time, name, exp, act));
    endtask

    // drives one frame of 16 bits msb first between two lrc high periods.
    task automatic run_row(input row_t r);
        sample_t v;
        int      b;
        int      cyc;
        v = r.value;
        if (v == '0) begin
            for (b = 0; b < 16; b++) v = {v[14:0], rand_bit()};
        end
        if (r.keep) exp_q.push_back(v);
        if (r.act == ACT_START) exp_addr = '0;
        for (cyc = 0; cyc < FRAME_CYCLES; cyc++) begin
            lrc   = (cyc < 2 || cyc >= 18);
            sdata = (cyc >= 2 && cyc < 18) ? v[17 - cyc] : 1'b0;
            start = (cyc == 0) && (r.act == ACT_START);
            stop  = (cyc == 0) && (r.act == ACT_STOP);
            pause = ((cyc == 0) && (r.act == ACT_PAUSE || r.act == ACT_RESUME)) ||
                    ((cyc == 10) && (r.act == ACT_CUT));   // cuts the frame mid-way.
            grant = grant_for(r.gnt);
            @(posedge clk);
            #2;
        end
        check_flag("o_busy", r.busy, busy);
        check_flag("o_full", r.full, full);
        check_flag("o_overrun", r.ovr, overrun);
    endtask

    // **************************************************
    // sram model
    // **************************************************
    always @(negedge clk) begin
        if (!rst_n && sram_we === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("unexpected sram write to address %0d at %0t ns",
                                    sram_addr, $time));
            end else begin
                check_addr("o_sram_addr", exp_addr, sram_addr);
                check_sample("o_sram_data", exp_q.pop_front(), sram_data);
                exp_addr = exp_addr + 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("timeout: the test table did not finish in the allowed time");
    end

    initial begin
        int n;
        int waits;
        rst_n    = 1'b1;                              // reset is active high.
        lrc      = 1'b0;
        sdata    = 1'b0;
        start    = 1'b0;
        pause    = 1'b0;
        stop     = 1'b0;
        grant    = 1'b0;
        exp_addr = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b0;
        @(posedge clk);
        #2;
        check_flag("o_busy", 1'b0, busy);
        check_flag("o_full", 1'b0, full);
        check_flag("o_overrun", 1'b0, overrun);
        check_flag("o_sram_we", 1'b0, sram_we);
        check_addr("o_sram_addr", '0, sram_addr);
        for (n = 0; n < NUM_ROWS; n++) run_row(rows[n]);
        grant = 1'b1;
        waits = 0;
        while (exp_q.size() != 0 && waits < 4 * FRAME_CYCLES) begin
            @(posedge clk);
            waits++;
        end
        if (exp_q.size() != 0) begin
            abort_run("buffered samples were never written to the sram");
        end else begin
            repeat (2 * FRAME_CYCLES) @(posedge clk);  // stray writes show up here.
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule
